/* verilog.f */
rtl/cop_pkg.sv
rtl/cop_cpr_bank.sv
rtl/cop_ctrl.sv
rtl/cop_mem_port.sv
rtl/cop_vtx_capture.sv
rtl/cop_top.sv
sim/tb_cop_top.sv

/* sim/tb_cop_top.sv */
// Testbench for the coprocessor top level. Issues random instructions,
// models a stalling memory and checks each verification record.
`timescale 1ns/1ps

module tb_cop_top;

localparam int unsigned num_insns     = 300;
localparam int unsigned timeout_limit = num_insns * 40;   // Cycles

logic                 g_clk;
logic                 g_resetn;
logic                 cpu_insn_req;
logic                 cpu_abort_req;
cop_pkg::cpu_req_t    cpu_req;
logic                 cop_insn_ack;
logic                 cop_insn_rsp;
cop_pkg::cop_rsp_t    cop_rsp;
logic                 cpu_insn_ack;
logic                 cop_mem_cen;
cop_pkg::mem_req_t    cop_mem_req;
logic [31:0]          cop_mem_rdata;
logic                 cop_mem_stall;
logic                 cop_mem_error;
cop_pkg::vtx_record_t vtx;

cop_pkg::cpr_file_t   model_cprs;           // Reference CPR state
logic [31:0]          model_mem [0:63];     // Reference memory
logic [31:0]          bus_mem [0:63];       // Memory behind the bus
cop_pkg::vtx_record_t exp_q [$];            // Expected records, issue order
cop_pkg::vtx_record_t cmp_exp;
logic [31:0]          drv_rng;              // Instruction stream
logic [31:0]          mem_rng;              // Stall pattern
logic                 mem_p_cen;
int unsigned          mismatch_count;
int unsigned          other_count;
int unsigned          records_seen;
int unsigned          exp_accesses;
int unsigned          bus_accesses;
int unsigned          cycle_count;

cop_top dut_i (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .cpu_insn_req (cpu_insn_req),
    .cpu_abort_req(cpu_abort_req),
    .cpu_req      (cpu_req),
    .cop_insn_ack (cop_insn_ack),
    .cop_insn_rsp (cop_insn_rsp),
    .cop_rsp      (cop_rsp),
    .cpu_insn_ack (cpu_insn_ack),
    .cop_mem_cen  (cop_mem_cen),
    .cop_mem_req  (cop_mem_req),
    .cop_mem_rdata(cop_mem_rdata),
    .cop_mem_stall(cop_mem_stall),
    .cop_mem_error(cop_mem_error),
    .vtx          (vtx)
);

// ----------------------------------------------------------------------
// Helpers

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] draw();
    drv_rng = xorshift(drv_rng);
    return drv_rng;
endfunction

function automatic logic in_err_window(input logic [31:0] addr);
    return addr[31:8] == 24'h000020;        // 0x2000..0x20ff faults
endfunction

function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
endfunction

task automatic check_value(input string what, input logic [511:0] got,
                           input logic [511:0] exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
endtask

// Applies the instruction rules to the model state, returns the record
function automatic cop_pkg::vtx_record_t ref_execute(input logic [31:0] enc,
                                                     input logic [31:0] rs1,
                                                     input logic        abort);
    cop_pkg::vtx_record_t r;
    logic [3:0]           funct;
    logic [3:0]           crd;
    logic [3:0]           crs1;
    logic [3:0]           crs2;
    logic                 known;
    logic                 is_mem;
    r      = '0;
    funct  = enc[31:28];
    crd    = enc[10:7];
    crs1   = enc[18:15];
    crs2   = enc[23:20];
    known  = funct == cop_pkg::funct_mv2cop || funct == cop_pkg::funct_mv2gpr ||
             funct == cop_pkg::funct_add || funct == cop_pkg::funct_xor ||
             funct == cop_pkg::funct_ldw || funct == cop_pkg::funct_stw ||
             funct == cop_pkg::funct_nop;
    is_mem = funct == cop_pkg::funct_ldw || funct == cop_pkg::funct_stw;
    r.valid    = 1'b1;
    r.insn_enc = enc;
    r.rs1      = rs1;
    r.cprs_pre = model_cprs;
    if (abort) begin
        r.result = cop_pkg::result_abort;       // No effect at all
    end else if (enc[6:0] != cop_pkg::cop_opcode || !known) begin
        r.result = cop_pkg::result_bad_insn;
    end else if (is_mem && rs1[1:0] != 2'b00) begin
        r.result = cop_pkg::result_bad_addr;    // Never reaches the bus
    end else begin
        r.result = cop_pkg::result_ok;
        case (funct)
            cop_pkg::funct_mv2cop: model_cprs[crd] = rs1;
            cop_pkg::funct_add:    model_cprs[crd] = model_cprs[crs1] + model_cprs[crs2];
            cop_pkg::funct_xor:    model_cprs[crd] = model_cprs[crs1] ^ model_cprs[crs2];
            cop_pkg::funct_mv2gpr: begin
                r.wen   = 1'b1;
                r.waddr = enc[11:7];
                r.wdata = model_cprs[crs1];
            end
            cop_pkg::funct_ldw, cop_pkg::funct_stw: begin
                exp_accesses++;
                r.mem.valid = 1'b1;
                r.mem.wen   = funct == cop_pkg::funct_stw;
                r.mem.addr  = rs1;
                r.mem.ben   = 4'hf;
                r.mem.wdata = r.mem.wen ? model_cprs[crs2] : 32'h0;
                r.mem.error = in_err_window(rs1);
                r.mem.rdata = r.mem.error ? 32'h0 : model_mem[rs1[7:2]];  // Old word
                if (r.mem.error) begin
                    r.result = cop_pkg::result_bus_err;
                end else if (r.mem.wen) begin
                    model_mem[rs1[7:2]] = r.mem.wdata;
                end else begin
                    model_cprs[crd] = r.mem.rdata;
                end
            end
            default: ;                          // nop
        endcase
    end
    r.cprs_post = model_cprs;
    return r;
endfunction

task automatic compare_record(input cop_pkg::vtx_record_t got,
                              input cop_pkg::vtx_record_t exp, input int unsigned idx);
    string tag;
    tag = $sformatf("record %0d ", idx);
    check_value({tag, "insn_enc"}, got.insn_enc, exp.insn_enc);
    check_value({tag, "rs1"}, got.rs1, exp.rs1);
    check_value({tag, "result"}, got.result, exp.result);
    check_value({tag, "wen"}, got.wen, exp.wen);
    check_value({tag, "waddr"}, got.waddr, exp.waddr);
    check_value({tag, "wdata"}, got.wdata, exp.wdata);
    check_value({tag, "mem.valid"}, got.mem.valid, exp.mem.valid);
    check_value({tag, "mem.wen"}, got.mem.wen, exp.mem.wen);
    check_value({tag, "mem.addr"}, got.mem.addr, exp.mem.addr);
    check_value({tag, "mem.wdata"}, got.mem.wdata, exp.mem.wdata);
    check_value({tag, "mem.ben"}, got.mem.ben, exp.mem.ben);
    check_value({tag, "mem.rdata"}, got.mem.rdata, exp.mem.rdata);
    check_value({tag, "mem.error"}, got.mem.error, exp.mem.error);
    check_value({tag, "cprs_pre"}, got.cprs_pre, exp.cprs_pre);
    check_value({tag, "cprs_post"}, got.cprs_post, exp.cprs_post);
endtask

// ----------------------------------------------------------------------
// CPU side

task automatic make_insn(output logic [31:0] enc, output logic [31:0] rs1,
                         output logic abort);
    logic [31:0] r;
    enc      = draw();                      // Random register fields
    rs1      = draw();                      // Full range, so adds wrap
    r        = draw();
    abort    = r[11:8] == 4'h0;             // About one in sixteen
    enc[6:0] = cop_pkg::cop_opcode;
    case (r[3:0])
        4'd0, 4'd1, 4'd2: enc[31:28] = cop_pkg::funct_mv2cop;
        4'd3:             enc[31:28] = cop_pkg::funct_mv2gpr;
        4'd4, 4'd5:       enc[31:28] = cop_pkg::funct_add;
        4'd6:             enc[31:28] = cop_pkg::funct_xor;
        4'd7, 4'd8, 4'd9, 4'd10: begin
            enc[31:28] = r[0] ? cop_pkg::funct_stw : cop_pkg::funct_ldw;
            rs1        = 32'h1000 | {r[21:16], 2'b00};
        end
        4'd11: enc[31:28] = cop_pkg::funct_nop;
        4'd12: enc[31:28] = 4'h6 + r[18:16];            // Unused codes 6..d
        4'd13: enc[6:0]   = cop_pkg::cop_opcode ^ (r[22:16] | 7'h01);
        4'd14: begin                                    // Misaligned
            enc[31:28] = r[16] ? cop_pkg::funct_stw : cop_pkg::funct_ldw;
            rs1        = 32'h1000 | {r[21:16], 2'b00};
            rs1[1:0]   = r[23:22] == 2'b00 ? 2'b11 : r[23:22];
        end
        default: begin                                  // Error window
            enc[31:28] = r[16] ? cop_pkg::funct_stw : cop_pkg::funct_ldw;
            rs1        = 32'h2000 | {r[21:16], 2'b00};
        end
    endcase
endtask

// Called at a rising edge, returns at the retirement edge
task automatic run_insn(input logic [31:0] enc, input logic [31:0] rs1,
                        input logic abort, input cop_pkg::vtx_record_t exp);
    cop_pkg::cop_rsp_t held;
    cop_pkg::cop_rsp_t exp_rsp;
    logic [31:0]       r;
    cpu_insn_req     <= 1'b1;
    cpu_abort_req    <= abort;
    cpu_req.insn_enc <= enc;
    cpu_req.rs1      <= rs1;
    do begin
        @(posedge g_clk);
    end while (cop_insn_ack !== 1'b1);      // Accepted at this edge
    cpu_insn_req  <= 1'b0;
    cpu_abort_req <= 1'b0;
    while (cop_insn_rsp !== 1'b1) @(posedge g_clk);
    held           = cop_rsp;
    exp_rsp.wen    = exp.wen;               // Response as the rules give it
    exp_rsp.waddr  = exp.waddr;
    exp_rsp.wdata  = exp.wdata;
    exp_rsp.result = exp.result;
    check_value("rsp payload", held, exp_rsp);
    r    = draw();
    repeat (r[1:0]) begin                   // Back-pressure on the response
        @(posedge g_clk);
        check_value("rsp held before ack", cop_insn_rsp, 1'b1);
        check_value("rsp payload held", cop_rsp, held);
    end
    cpu_insn_ack <= 1'b1;
    @(posedge g_clk);
    check_value("rsp at retirement", cop_insn_rsp, 1'b1);
    check_value("payload at retirement", cop_rsp, held);
    cpu_insn_ack <= 1'b0;
endtask

task automatic finish_run();
    $display("Summary: %0d records, %0d mismatches, %0d other errors",
             records_seen, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
endtask

// ----------------------------------------------------------------------
// Clock, memory model, record checker, watchdog

initial begin
    g_clk = 1'b0;
    forever #4 g_clk = ~g_clk;              // 8 ns period
end

// Cen stays up two cycles at least under the port's completion rule
always @(posedge g_clk) begin
    mem_rng = xorshift(mem_rng);
    cop_mem_stall <= mem_rng[2:0] < 3'd3;
    if (cop_mem_cen === 1'b1) begin
        cop_mem_error <= in_err_window(cop_mem_req.addr);
        cop_mem_rdata <= in_err_window(cop_mem_req.addr) ? 32'h0 :
                         bus_mem[cop_mem_req.addr[7:2]];
    end else begin
        cop_mem_error <= 1'b0;
        cop_mem_rdata <= 32'h0;
    end
    if (cop_mem_cen === 1'b1 && mem_p_cen === 1'b1 && !cop_mem_stall) begin
        bus_accesses++;
        if (cop_mem_req.wen && !in_err_window(cop_mem_req.addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (cop_mem_req.ben[b]) begin
                    bus_mem[cop_mem_req.addr[7:2]][8*b +: 8] = cop_mem_req.wdata[8*b +: 8];
                end
            end
        end
    end
    mem_p_cen <= cop_mem_cen;
end

always @(posedge g_clk) begin
    if (g_resetn === 1'b1 && vtx.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
            other_count++;
            $display("Error at %0t: record seen with no instruction outstanding", $time);
        end else begin
            cmp_exp = exp_q.pop_front();
            compare_record(vtx, cmp_exp, records_seen);
        end
        records_seen++;
    end
end

initial begin
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
        @(posedge g_clk);
        cycle_count++;
    end
    other_count++;
    $display("Timeout: DUT stopped retiring instructions after %0d cycles", cycle_count);
    finish_run();
end

// ----------------------------------------------------------------------
// Main sequence

initial begin : main_seq
    logic [31:0]          enc;
    logic [31:0]          rs1;
    logic                 abort;
    cop_pkg::vtx_record_t exp_rec;
    g_resetn       = 1'b0;
    cpu_insn_req   = 1'b0;
    cpu_abort_req  = 1'b0;
    cpu_req        = '0;
    cpu_insn_ack   = 1'b0;
    cop_mem_rdata  = 32'h0;
    cop_mem_stall  = 1'b0;
    cop_mem_error  = 1'b0;
    mem_p_cen      = 1'b0;
    drv_rng        = 32'd25782;
    mem_rng        = 32'd25782 ^ 32'h9e37_79b9;   // Own stream for stalls
    mismatch_count = 0;
    other_count    = 0;
    records_seen   = 0;
    exp_accesses   = 0;
    bus_accesses   = 0;
    model_cprs     = '0;
    for (int i = 0; i < 64; i++) begin
        model_mem[i] = fill_word(32'h1000 + i * 4);
        bus_mem[i]   = model_mem[i];
    end
    repeat (4) @(posedge g_clk);
    g_resetn <= 1'b1;
    repeat (3) begin                        // Quiet until the first request
        @(posedge g_clk);
        check_value("ack after reset", cop_insn_ack, 1'b0);
        check_value("rsp after reset", cop_insn_rsp, 1'b0);
        check_value("cen after reset", cop_mem_cen, 1'b0);
        check_value("record valid after reset", vtx.valid, 1'b0);
    end
    for (int n = 0; n < num_insns; n++) begin
        make_insn(enc, rs1, abort);
        exp_rec = ref_execute(enc, rs1, abort);
        exp_q.push_back(exp_rec);
        run_insn(enc, rs1, abort, exp_rec);
    end
    while (exp_q.size() != 0) @(posedge g_clk);
    repeat (2) @(posedge g_clk);            // Catch a stray extra record
    for (int i = 0; i < 64; i++) begin
        check_value($sformatf("memory word %0d", i), bus_mem[i], model_mem[i]);
    end
    check_value("record count", records_seen, num_insns);
    check_value("memory access count", bus_accesses, exp_accesses);
    finish_run();
end

endmodule

/* rtl/cop_top.sv */
// Coprocessor top level. Ties the controller, CPR bank and memory port
// together and exposes the verification record beside the buses.
`timescale 1ns/1ps

module cop_top (
    input  logic                 g_clk,         // Global clock
    input  logic                 g_resetn,      // Sync active low reset
    input  logic                 cpu_insn_req,
    input  logic                 cpu_abort_req,
    input  cop_pkg::cpu_req_t    cpu_req,
    output logic                 cop_insn_ack,
    output logic                 cop_insn_rsp,
    output cop_pkg::cop_rsp_t    cop_rsp,
    input  logic                 cpu_insn_ack,
    output logic                 cop_mem_cen,
    output cop_pkg::mem_req_t    cop_mem_req,
    input  logic [31:0]          cop_mem_rdata,
    input  logic                 cop_mem_stall,
    input  logic                 cop_mem_error,
    output cop_pkg::vtx_record_t vtx            // Verification record
);

// Controller to CPR bank
logic [3:0]         cpr_rd_idx_a;
logic [3:0]         cpr_rd_idx_b;
logic [31:0]        cpr_rd_data_a;
logic [31:0]        cpr_rd_data_b;
logic               cpr_wr_en;
logic [3:0]         cpr_wr_idx;
logic [31:0]        cpr_wr_data;
cop_pkg::cpr_file_t cpr_snoop;

// Controller to memory port
logic               mem_start;
cop_pkg::mem_req_t  mem_req;
logic               mem_done;
cop_pkg::mem_rsp_t  mem_rsp;
cop_pkg::mem_rsp_t  mem_bus_rsp;   // Unregistered bus response, for capture

assign mem_bus_rsp.rdata = cop_mem_rdata;
assign mem_bus_rsp.error = cop_mem_error;

cop_ctrl ctrl_i (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .cpu_insn_req (cpu_insn_req),
    .cpu_abort_req(cpu_abort_req),
    .cpu_req      (cpu_req),
    .cop_insn_ack (cop_insn_ack),
    .cop_insn_rsp (cop_insn_rsp),
    .cop_rsp      (cop_rsp),
    .cpu_insn_ack (cpu_insn_ack),
    .cpr_rd_idx_a (cpr_rd_idx_a),
    .cpr_rd_idx_b (cpr_rd_idx_b),
    .cpr_rd_data_a(cpr_rd_data_a),
    .cpr_rd_data_b(cpr_rd_data_b),
    .cpr_wr_en    (cpr_wr_en),
    .cpr_wr_idx   (cpr_wr_idx),
    .cpr_wr_data  (cpr_wr_data),
    .mem_start    (mem_start),
    .mem_req      (mem_req),
    .mem_done     (mem_done),
    .mem_rsp      (mem_rsp)
);

cop_cpr_bank cpr_bank_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .rd_idx_a (cpr_rd_idx_a),
    .rd_idx_b (cpr_rd_idx_b),
    .rd_data_a(cpr_rd_data_a),
    .rd_data_b(cpr_rd_data_b),
    .wr_en    (cpr_wr_en),
    .wr_idx   (cpr_wr_idx),
    .wr_data  (cpr_wr_data),
    .snoop    (cpr_snoop)
);

cop_mem_port mem_port_i (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .mem_start    (mem_start),
    .req          (mem_req),
    .mem_done     (mem_done),
    .rsp          (mem_rsp),
    .cop_mem_cen  (cop_mem_cen),
    .cop_mem_req  (cop_mem_req),
    .cop_mem_rdata(cop_mem_rdata),
    .cop_mem_stall(cop_mem_stall),
    .cop_mem_error(cop_mem_error)
);

// Capture taps the top-level buses directly
cop_vtx_capture vtx_capture_i (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .cpu_insn_req (cpu_insn_req),
    .cop_insn_ack (cop_insn_ack),
    .cpu_req      (cpu_req),
    .cop_insn_rsp (cop_insn_rsp),
    .cpu_insn_ack (cpu_insn_ack),
    .cop_rsp      (cop_rsp),
    .cop_mem_cen  (cop_mem_cen),
    .cop_mem_stall(cop_mem_stall),
    .cop_mem_req  (cop_mem_req),
    .cop_mem_rsp  (mem_bus_rsp),
    .cpr_snoop    (cpr_snoop),
    .vtx          (vtx)
);

endmodule

/* rtl/cop_vtx_capture.sv */
// Transaction capture. Watches the CPU and memory buses and the CPR bank
// and emits one verification record per retired instruction.
`timescale 1ns/1ps

module cop_vtx_capture (
    input  logic                 g_clk,         // Global clock
    input  logic                 g_resetn,      // Sync active low reset
    input  logic                 cpu_insn_req,
    input  logic                 cop_insn_ack,
    input  cop_pkg::cpu_req_t    cpu_req,
    input  logic                 cop_insn_rsp,
    input  logic                 cpu_insn_ack,
    input  cop_pkg::cop_rsp_t    cop_rsp,
    input  logic                 cop_mem_cen,
    input  logic                 cop_mem_stall,
    input  cop_pkg::mem_req_t    cop_mem_req,
    input  cop_pkg::mem_rsp_t    cop_mem_rsp,   // Raw bus response
    input  cop_pkg::cpr_file_t   cpr_snoop,
    output cop_pkg::vtx_record_t vtx
);

logic               accept_edge;    // Instruction accepted at this edge
logic               retire_edge;    // Instruction retired at this edge
logic               p_cen;
logic               cen_rise;       // First edge with cen high
logic               txn_finish;     // Bus completion edge
cop_pkg::cpu_req_t  req_q;
cop_pkg::cpr_file_t cprs_pre_q;
cop_pkg::mem_txn_t  txn_q;

assign accept_edge = cpu_insn_req && cop_insn_ack;
assign retire_edge = cop_insn_rsp && cpu_insn_ack;
assign cen_rise    = cop_mem_cen && !p_cen;
assign txn_finish  = cop_mem_cen && p_cen && !cop_mem_stall;    // Same rule as the bus

// ------------------------------------------------------------------
// Snapshots at acceptance

always_ff @(posedge g_clk) begin
    if (accept_edge) begin
        req_q      <= cpu_req;
        cprs_pre_q <= cpr_snoop;        // CPRs before execution
    end
end

// ------------------------------------------------------------------
// Single memory transaction

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        p_cen       <= 1'b0;
        txn_q.valid <= 1'b0;
    end else begin
        p_cen <= cop_mem_cen;
        if (accept_edge) begin
            txn_q <= '0;                // New instruction, no access yet
        end else if (cen_rise) begin
            txn_q.valid <= 1'b1;
            txn_q.wen   <= cop_mem_req.wen;
            txn_q.addr  <= cop_mem_req.addr;
            txn_q.wdata <= cop_mem_req.wdata;
            txn_q.ben   <= cop_mem_req.ben;
        end
        if (txn_finish) begin
            txn_q.rdata <= cop_mem_rsp.rdata;
            txn_q.error <= cop_mem_rsp.error;
        end
    end
end

// ------------------------------------------------------------------
// Record output, valid for one cycle after retirement

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        vtx.valid <= 1'b0;
    end else begin
        vtx.valid <= retire_edge;
        if (retire_edge) begin
            vtx.insn_enc  <= req_q.insn_enc;
            vtx.rs1       <= req_q.rs1;
            vtx.wen       <= cop_rsp.wen;
            vtx.waddr     <= cop_rsp.waddr;
            vtx.wdata     <= cop_rsp.wdata;
            vtx.result    <= cop_rsp.result;
            vtx.mem       <= txn_q;
            vtx.cprs_pre  <= cprs_pre_q;
            vtx.cprs_post <= cpr_snoop;  // Includes the instruction's write
        end
    end
end

endmodule

/* rtl/cop_mem_port.sv */
// Memory port. Issues one word access per start strobe, holds it
// through stalls and hands back the read data and error on completion.
`timescale 1ns/1ps

module cop_mem_port (
    input  logic              g_clk,         // Global clock
    input  logic              g_resetn,      // Sync active low reset
    input  logic              mem_start,     // One-cycle launch strobe
    input  cop_pkg::mem_req_t req,
    output logic              mem_done,      // One cycle after completion
    output cop_pkg::mem_rsp_t rsp,
    output logic              cop_mem_cen,   // Bus chip enable
    output cop_pkg::mem_req_t cop_mem_req,
    input  logic [31:0]       cop_mem_rdata,
    input  logic              cop_mem_stall,
    input  logic              cop_mem_error
);

logic p_cen;        // cen as it was one cycle back
logic txn_end;      // Completion at this edge

// Needs cen from the previous cycle and no stall
assign txn_end = cop_mem_cen && p_cen && !cop_mem_stall;

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        cop_mem_cen <= 1'b0;
        p_cen       <= 1'b0;
        mem_done    <= 1'b0;
    end else begin
        p_cen    <= cop_mem_cen;
        mem_done <= txn_end;
        if (mem_start) begin
            cop_mem_cen <= 1'b1;
        end else if (txn_end) begin
            cop_mem_cen <= 1'b0;        // Drops at completion edge
        end
    end
end

// Request held stable while cen is high
always_ff @(posedge g_clk) begin
    if (mem_start) begin
        cop_mem_req <= req;
    end
    if (txn_end) begin
        rsp.rdata <= cop_mem_rdata;
        rsp.error <= cop_mem_error;
    end
end

endmodule

/* rtl/cop_ctrl.sv */
// Coprocessor control. Accepts one instruction at a time, decodes and
// executes it, drives CPR and memory work, and holds the CPU response.
`timescale 1ns/1ps

module cop_ctrl (
    input  logic              g_clk,            // Global clock
    input  logic              g_resetn,         // Sync active low reset
    input  logic              cpu_insn_req,     // CPU instruction request
    input  logic              cpu_abort_req,    // Abort level, sampled on accept
    input  cop_pkg::cpu_req_t cpu_req,
    output logic              cop_insn_ack,     // One-cycle accept pulse
    output logic              cop_insn_rsp,     // Response valid
    output cop_pkg::cop_rsp_t cop_rsp,
    input  logic              cpu_insn_ack,     // CPU takes the response
    output logic [3:0]        cpr_rd_idx_a,
    output logic [3:0]        cpr_rd_idx_b,
    input  logic [31:0]       cpr_rd_data_a,
    input  logic [31:0]       cpr_rd_data_b,
    output logic              cpr_wr_en,
    output logic [3:0]        cpr_wr_idx,
    output logic [31:0]       cpr_wr_data,
    output logic              mem_start,        // Launch one memory access
    output cop_pkg::mem_req_t mem_req,
    input  logic              mem_done,         // Access finished, rsp valid
    input  cop_pkg::mem_rsp_t mem_rsp
);

typedef enum logic [2:0] {
    st_idle,        // Waiting for a request
    st_accept,      // Ack high, latch on this edge
    st_execute,     // Decode, ALU, CPR write or memory launch
    st_mem_wait,    // Memory access outstanding
    st_respond      // Response held until CPU ack
} state_e;

state_e               state;
cop_pkg::cpu_req_t    insn_q;       // Accepted instruction
logic                 abort_q;

logic [31:0]          enc;
logic [3:0]           funct;
logic                 funct_ok;     // Known function code
logic                 is_ldw;
logic                 is_stw;
logic                 is_mem;
logic                 alu_wen;      // Register op writes crd
logic [31:0]          alu_out;
cop_pkg::cop_result_e exe_result;
logic                 exe_ok;
cop_pkg::cop_rsp_t    exe_rsp;      // Response of a non-memory instruction

// ------------------------------------------------------------------
// Decode

assign enc    = insn_q.insn_enc;
assign funct  = enc[cop_pkg::funct_hi:cop_pkg::funct_lo];
assign is_ldw = funct == cop_pkg::funct_ldw;
assign is_stw = funct == cop_pkg::funct_stw;
assign is_mem = is_ldw || is_stw;

assign cpr_rd_idx_a = enc[cop_pkg::crs1_hi:cop_pkg::crs1_lo];
assign cpr_rd_idx_b = enc[cop_pkg::crs2_hi:cop_pkg::crs2_lo];

always_comb begin
    funct_ok = 1'b1;
    alu_wen  = 1'b0;
    alu_out  = '0;
    case (funct)
        cop_pkg::funct_mv2cop: begin
            alu_wen = 1'b1;
            alu_out = insn_q.rs1;
        end
        cop_pkg::funct_add: begin
            alu_wen = 1'b1;
            alu_out = cpr_rd_data_a + cpr_rd_data_b;   // Wraps at 32 bits
        end
        cop_pkg::funct_xor: begin
            alu_wen = 1'b1;
            alu_out = cpr_rd_data_a ^ cpr_rd_data_b;
        end
        cop_pkg::funct_mv2gpr,
        cop_pkg::funct_ldw,
        cop_pkg::funct_stw,
        cop_pkg::funct_nop: funct_ok = 1'b1;
        default:            funct_ok = 1'b0;
    endcase
end

// Abort wins over every decode error
always_comb begin
    if (abort_q) begin
        exe_result = cop_pkg::result_abort;
    end else if (enc[cop_pkg::opc_hi:0] != cop_pkg::cop_opcode || !funct_ok) begin
        exe_result = cop_pkg::result_bad_insn;
    end else if (is_mem && insn_q.rs1[1:0] != 2'b00) begin
        exe_result = cop_pkg::result_bad_addr;  // Misaligned, no access
    end else begin
        exe_result = cop_pkg::result_ok;
    end
end

assign exe_ok = exe_result == cop_pkg::result_ok;

always_comb begin
    exe_rsp        = '0;                // wdata and waddr zero unless wen
    exe_rsp.result = exe_result;
    if (exe_ok && funct == cop_pkg::funct_mv2gpr) begin
        exe_rsp.wen   = 1'b1;
        exe_rsp.waddr = enc[cop_pkg::gpr_hi:cop_pkg::gpr_lo];
        exe_rsp.wdata = cpr_rd_data_a;
    end
end

// ------------------------------------------------------------------
// CPR writeback and memory launch

always_comb begin
    cpr_wr_en   = 1'b0;
    cpr_wr_idx  = enc[cop_pkg::crd_hi:cop_pkg::crd_lo];
    cpr_wr_data = alu_out;
    if (state == st_execute) begin
        cpr_wr_en = alu_wen && exe_ok;
    end else if (state == st_mem_wait && mem_done && is_ldw && !mem_rsp.error) begin
        cpr_wr_en   = 1'b1;             // Load data lands in crd
        cpr_wr_data = mem_rsp.rdata;
    end
end

assign mem_start     = state == st_execute && exe_ok && is_mem;
assign mem_req.wen   = is_stw;
assign mem_req.addr  = insn_q.rs1;
assign mem_req.wdata = is_stw ? cpr_rd_data_b : 32'h0;    // crs2 for stores
assign mem_req.ben   = 4'hf;                               // Whole words only

// ------------------------------------------------------------------
// State machine

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        state        <= st_idle;
        cop_insn_ack <= 1'b0;
        cop_insn_rsp <= 1'b0;
    end else begin
        cop_insn_ack <= 1'b0;           // Pulse only
        case (state)
            st_idle: if (cpu_insn_req) begin
                cop_insn_ack <= 1'b1;
                state        <= st_accept;
            end
            st_accept: state <= cpu_insn_req ? st_execute : st_idle;
            st_execute: if (mem_start) begin
                state <= st_mem_wait;
            end else begin
                cop_insn_rsp <= 1'b1;
                state        <= st_respond;
            end
            st_mem_wait: if (mem_done) begin
                cop_insn_rsp <= 1'b1;
                state        <= st_respond;
            end
            st_respond: if (cpu_insn_ack) begin
                cop_insn_rsp <= 1'b0;   // Retired
                state        <= st_idle;
            end
            default: state <= st_idle;
        endcase
    end
end

// Instruction latch and response payload
always_ff @(posedge g_clk) begin
    if (state == st_accept && cpu_insn_req) begin
        insn_q  <= cpu_req;
        abort_q <= cpu_abort_req;
    end
    if (state == st_execute) begin
        cop_rsp <= exe_rsp;
    end else if (state == st_mem_wait && mem_done) begin
        cop_rsp        <= '0;
        cop_rsp.result <= mem_rsp.error ? cop_pkg::result_bus_err : cop_pkg::result_ok;
    end
end

endmodule

/* rtl/cop_cpr_bank.sv */
// Sixteen 32-bit coprocessor registers, two async reads and one write.
// The full bank is also exported for the capture block.
`timescale 1ns/1ps

module cop_cpr_bank (
    input  logic               g_clk,      // Global clock
    input  logic               g_resetn,   // Sync active low reset
    input  logic [3:0]         rd_idx_a,
    input  logic [3:0]         rd_idx_b,
    output logic [31:0]        rd_data_a,
    output logic [31:0]        rd_data_b,
    input  logic               wr_en,
    input  logic [3:0]         wr_idx,
    input  logic [31:0]        wr_data,
    output cop_pkg::cpr_file_t snoop       // All registers, for verification
);

cop_pkg::cpr_file_t cprs;

assign rd_data_a = cprs[rd_idx_a];     // Read ports see last write
assign rd_data_b = cprs[rd_idx_b];
assign snoop     = cprs;

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        cprs <= '0;                     // All CPRs start at zero
    end else if (wr_en) begin
        cprs[wr_idx] <= wr_data;
    end
end

endmodule

/* rtl/cop_pkg.sv */
// Shared encodings and packed payload types of the crypto coprocessor.
// All other design files refer to these by scoped name.
package cop_pkg;

// ------------------------------------------------------------------
// Instruction encoding

localparam logic [6:0] cop_opcode = 7'b0001011;    // Custom-0 opcode space

localparam int unsigned opc_hi   = 6;   // Opcode in bits 6..0
localparam int unsigned crd_lo   = 7;   // CPR destination
localparam int unsigned crd_hi   = 10;
localparam int unsigned gpr_lo   = 7;   // GPR destination, 5 bits
localparam int unsigned gpr_hi   = 11;
localparam int unsigned crs1_lo  = 15;
localparam int unsigned crs1_hi  = 18;
localparam int unsigned crs2_lo  = 20;
localparam int unsigned crs2_hi  = 23;
localparam int unsigned funct_lo = 28;  // Function code, top nibble
localparam int unsigned funct_hi = 31;

typedef enum logic [3:0] {
    funct_mv2cop = 4'h0,    // CPR <- rs1
    funct_mv2gpr = 4'h1,    // GPR <- CPR
    funct_add    = 4'h2,
    funct_xor    = 4'h3,
    funct_ldw    = 4'h4,
    funct_stw    = 4'h5,
    funct_nop    = 4'hf
} cop_funct_e;

typedef enum logic [2:0] {
    result_ok       = 3'd0,
    result_abort    = 3'd1,
    result_bad_insn = 3'd2,
    result_bad_addr = 3'd3,
    result_bus_err  = 3'd4
} cop_result_e;

// ------------------------------------------------------------------
// Interface payloads

typedef struct packed {
    logic [31:0] insn_enc;  // Encoded instruction
    logic [31:0] rs1;       // GPR source value
} cpu_req_t;

typedef struct packed {
    logic        wen;       // GPR writeback
    logic [4:0]  waddr;
    logic [31:0] wdata;
    cop_result_e result;
} cop_rsp_t;

typedef struct packed {
    logic        wen;
    logic [31:0] addr;      // Word aligned
    logic [31:0] wdata;
    logic [3:0]  ben;
} mem_req_t;

typedef struct packed {
    logic [31:0] rdata;
    logic        error;
} mem_rsp_t;

// One memory access as seen on the bus
typedef struct packed {
    logic        valid;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  ben;
    logic [31:0] rdata;
    logic        error;
} mem_txn_t;

typedef logic [15:0][31:0] cpr_file_t;     // Whole CPR bank

// Per-instruction verification record
typedef struct packed {
    logic        valid;
    logic [31:0] insn_enc;
    logic [31:0] rs1;
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    cop_result_e result;
    mem_txn_t    mem;
    cpr_file_t   cprs_pre;
    cpr_file_t   cprs_post;
} vtx_record_t;

endpackage
